// File: files.f
+incdir+include
hw/riscv_pkg.sv
hw/riscv_regfile.sv
hw/riscv_issue_stage.sv
hw/riscv_alu.sv
hw/riscv_branch_unit.sv
hw/riscv_commit_stage.sv
hw/riscv_datapath.sv
verification/riscv_datapath_tb.sv

// File: hw/riscv_alu.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_alu import riscv_pkg::*; (
  input  ex_stage_t i_ex,
  output xlen_t     o_alu_result
);

  localparam int SHAMT_W = $clog2(`RISCV_XLEN); // 6 for rv64

  xlen_t              op_a;
  xlen_t              op_b;
  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  assign op_a  = i_ex.asel ? i_ex.pc  : i_ex.rs1_data;
  assign op_b  = i_ex.bsel ? i_ex.imm : i_ex.rs2_data;
  assign shamt = op_b[SHAMT_W-1:0];

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    unique case (i_ex.alu_op)
      ALU_ADD:  o_alu_result = op_a + op_b;
      ALU_SUB:  o_alu_result = op_a - op_b;
      ALU_AND:  o_alu_result = op_a & op_b;
      ALU_OR:   o_alu_result = op_a | op_b;
      ALU_XOR:  o_alu_result = op_a ^ op_b;
      ALU_SLL:  o_alu_result = op_a << shamt;
      ALU_SRL:  o_alu_result = op_a >> shamt;
      ALU_SRA:  o_alu_result = xlen_t'($signed(op_a) >>> shamt);
      ALU_SLT:  o_alu_result = xlen_t'(lt_s);  // 0 or 1
      ALU_SLTU: o_alu_result = xlen_t'(lt_u);
      default:  o_alu_result = op_a + op_b;    // unused codes behave as add
    endcase
  end

endmodule

// File: hw/riscv_branch_unit.sv
`timescale 1ns/1ps

module riscv_branch_unit import riscv_pkg::*; (
  input  ex_stage_t i_ex,
  output logic      o_taken
);

  logic eq;
  logic lt_s;
  logic lt_u;

  // always register operands, never pc or imm
  assign eq   = i_ex.rs1_data == i_ex.rs2_data;
  assign lt_s = $signed(i_ex.rs1_data) < $signed(i_ex.rs2_data);
  assign lt_u = i_ex.rs1_data < i_ex.rs2_data;

  always_comb begin
    unique case (i_ex.bcond)
      BC_EQ:   o_taken = eq;
      BC_NE:   o_taken = !eq;
      BC_LT:   o_taken = lt_s;
      BC_GE:   o_taken = !lt_s;
      BC_LTU:  o_taken = lt_u;
      BC_GEU:  o_taken = !lt_u;
      default: o_taken = 1'b0; // BC_NONE
    endcase
  end

endmodule

// File: hw/riscv_commit_stage.sv
`timescale 1ns/1ps

module riscv_commit_stage import riscv_pkg::*; (
  input  logic      i_riscv_commit_clk,
  input  logic      i_rst_n,
  // from execute register
  input  ex_stage_t i_ex,
  input  logic      i_ex_valid,
  output logic      o_ex_ready,
  input  xlen_t     i_alu_result,
  input  logic      i_taken,
  // register file write port
  output logic      o_we,
  output reg_addr_t o_rd_addr,
  output xlen_t     o_rd_data,
  // result packet out
  output result_t   o_res,
  output logic      o_res_valid,
  input  logic      i_res_ready
);

  result_t res_d;
  result_t res_q;
  logic    res_valid_q;
  logic    move; // ex op enters the output register this edge

  // output slot free or being emptied
  assign o_ex_ready = !res_valid_q || i_res_ready;
  assign move       = i_ex_valid && o_ex_ready;

  always_comb begin
    res_d.pc       = i_ex.pc;
    res_d.rd       = i_ex.rd;
    res_d.rd_data  = i_ex.jump ? (i_ex.pc + xlen_t'(4)) : i_alu_result; // link value
    res_d.regw     = i_ex.regw;
    res_d.redirect = i_ex.jump || i_taken;
    res_d.target   = i_alu_result;
  end

  // write back on the same edge the op is committed
  assign o_we      = move && i_ex.regw;
  assign o_rd_addr = i_ex.rd;
  assign o_rd_data = res_d.rd_data;

  always_ff @(posedge i_riscv_commit_clk) begin
    if (!i_rst_n) begin
      res_valid_q <= 1'b0;
    end else if (move) begin
      res_valid_q <= 1'b1;
    end else if (i_res_ready) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_riscv_commit_clk) begin
    if (move) begin
      res_q <= res_d;
    end
  end

  assign o_res       = res_q;
  assign o_res_valid = res_valid_q;

endmodule

// File: hw/riscv_datapath.sv
`timescale 1ns/1ps

module riscv_datapath import riscv_pkg::*; (
  input  logic    i_riscv_datapath_clk,
  input  logic    i_rst_n,
  // decoded op in
  input  ex_op_t  i_op,
  input  logic    i_op_valid,
  output logic    o_op_ready,
  // result packet out
  output result_t o_res,
  output logic    o_res_valid,
  input  logic    i_res_ready
);

  // read port, issue <-> regfile
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  // execute register
  ex_stage_t ex;
  logic      ex_valid;
  logic      ex_ready;

  xlen_t     alu_result;
  logic      branch_taken;

  // write port, commit -> regfile
  logic      rd_we;
  reg_addr_t rd_addr;
  xlen_t     rd_data;

  riscv_regfile u_riscv_regfile (
    .i_riscv_regfile_clk (i_riscv_datapath_clk),
    .i_rst_n             (i_rst_n),
    .i_rs1_addr          (rs1_addr),
    .i_rs2_addr          (rs2_addr),
    .o_rs1_data          (rs1_data),
    .o_rs2_data          (rs2_data),
    .i_we                (rd_we),
    .i_rd_addr           (rd_addr),
    .i_rd_data           (rd_data)
  );

  riscv_issue_stage u_riscv_issue_stage (
    .i_riscv_issue_clk (i_riscv_datapath_clk),
    .i_rst_n           (i_rst_n),
    .i_op              (i_op),
    .i_op_valid        (i_op_valid),
    .o_op_ready        (o_op_ready),
    .o_rs1_addr        (rs1_addr),
    .o_rs2_addr        (rs2_addr),
    .i_rs1_data        (rs1_data),
    .i_rs2_data        (rs2_data),
    .o_ex              (ex),
    .o_ex_valid        (ex_valid),
    .i_ex_ready        (ex_ready)
  );

  riscv_alu u_riscv_alu (
    .i_ex         (ex),
    .o_alu_result (alu_result)
  );

  riscv_branch_unit u_riscv_branch_unit (
    .i_ex    (ex),
    .o_taken (branch_taken)
  );

  riscv_commit_stage u_riscv_commit_stage (
    .i_riscv_commit_clk (i_riscv_datapath_clk),
    .i_rst_n            (i_rst_n),
    .i_ex               (ex),
    .i_ex_valid         (ex_valid),
    .o_ex_ready         (ex_ready),
    .i_alu_result       (alu_result),
    .i_taken            (branch_taken),
    .o_we               (rd_we),
    .o_rd_addr          (rd_addr),
    .o_rd_data          (rd_data),
    .o_res              (o_res),
    .o_res_valid        (o_res_valid),
    .i_res_ready        (i_res_ready)
  );

endmodule

// File: hw/riscv_issue_stage.sv
`timescale 1ns/1ps

module riscv_issue_stage import riscv_pkg::*; (
  input  logic      i_riscv_issue_clk,
  input  logic      i_rst_n,
  // decoded op in
  input  ex_op_t    i_op,
  input  logic      i_op_valid,
  output logic      o_op_ready,
  // register file read port
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  input  xlen_t     i_rs1_data,
  input  xlen_t     i_rs2_data,
  // execute register out
  output ex_stage_t o_ex,
  output logic      o_ex_valid,
  input  logic      i_ex_ready
);

  ex_stage_t ex_q;
  ex_stage_t ex_d;
  logic      ex_valid_q;
  logic      ex_stall;   // execute register full and not draining
  logic      raw_hazard;
  logic      accept;

  // held op's destination for the hazard compare
  reg_addr_t held_rd;
  logic      held_writes;

  assign held_rd     = ex_q.rd;
  assign held_writes = ex_valid_q && ex_q.regw && (held_rd != '0);

  assign raw_hazard = i_op_valid && held_writes &&
                      ((held_rd == i_op.rs1) || (held_rd == i_op.rs2));

  assign ex_stall   = ex_valid_q && !i_ex_ready;
  assign o_op_ready = !ex_stall && !raw_hazard;
  assign accept     = i_op_valid && o_op_ready;

  assign o_rs1_addr = i_op.rs1;
  assign o_rs2_addr = i_op.rs2;

  always_comb begin
    ex_d.pc       = i_op.pc;
    ex_d.rd       = i_op.rd;
    ex_d.imm      = i_op.imm;
    ex_d.alu_op   = i_op.alu_op;
    ex_d.bcond    = i_op.bcond;
    ex_d.asel     = i_op.asel;
    ex_d.bsel     = i_op.bsel;
    ex_d.regw     = i_op.regw;
    ex_d.jump     = i_op.jump;
    ex_d.rs1_data = i_rs1_data; // operands captured with the op
    ex_d.rs2_data = i_rs2_data;
  end

  always_ff @(posedge i_riscv_issue_clk) begin
    if (!i_rst_n) begin
      ex_valid_q <= 1'b0;
    end else if (accept) begin
      ex_valid_q <= 1'b1;
    end else if (i_ex_ready) begin
      ex_valid_q <= 1'b0; // drained with nothing behind it
    end
  end

  // execute register payload
  always_ff @(posedge i_riscv_issue_clk) begin
    if (accept) begin
      ex_q <= ex_d;
    end
  end

  assign o_ex       = ex_q;
  assign o_ex_valid = ex_valid_q;

endmodule

// File: hw/riscv_pkg.sv
`include "riscv_macros.svh"

package riscv_pkg;

  typedef logic [`RISCV_XLEN-1:0]       xlen_t;     // data word or pc
  typedef logic [`RISCV_REG_ADDR_W-1:0] reg_addr_t; // register index

  // alu function select
  typedef enum logic [`RISCV_ALU_OP_W-1:0] {
    ALU_ADD  = 0,
    ALU_SUB  = 1,
    ALU_AND  = 2,
    ALU_OR   = 3,
    ALU_XOR  = 4,
    ALU_SLL  = 5,
    ALU_SRL  = 6,
    ALU_SRA  = 7,
    ALU_SLT  = 8,
    ALU_SLTU = 9
  } alu_op_e;

  // branch condition, none for non-branch ops
  typedef enum logic [`RISCV_BCOND_W-1:0] {
    BC_NONE = 0,
    BC_EQ   = 1,
    BC_NE   = 2,
    BC_LT   = 3,
    BC_GE   = 4,
    BC_LTU  = 5,
    BC_GEU  = 6
  } bcond_e;

  // operation as it arrives from decode
  typedef struct packed {
    xlen_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     imm;
    alu_op_e   alu_op;
    bcond_e    bcond;
    logic      asel;  // pc as operand a
    logic      bsel;  // imm as operand b
    logic      regw;
    logic      jump;
  } ex_op_t;

  // execute register, operands already read
  typedef struct packed {
    xlen_t     pc;
    reg_addr_t rd;
    xlen_t     imm;
    alu_op_e   alu_op;
    bcond_e    bcond;
    logic      asel;
    logic      bsel;
    logic      regw;
    logic      jump;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
  } ex_stage_t;

  typedef struct packed {
    xlen_t     pc;
    reg_addr_t rd;
    xlen_t     rd_data;
    logic      regw;
    logic      redirect; // jump or taken branch
    xlen_t     target;
  } result_t;

endpackage

// File: hw/riscv_regfile.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_regfile import riscv_pkg::*; (
  input  logic      i_riscv_regfile_clk,
  input  logic      i_rst_n,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  input  logic      i_we,
  input  reg_addr_t i_rd_addr,
  input  xlen_t     i_rd_data
);

  xlen_t regs [`RISCV_NUM_REGS];

  always_ff @(posedge i_riscv_regfile_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RISCV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd_addr != '0)) begin // x0 never written
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // async read, x0 reads zero
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// File: include/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath widths
`define RISCV_XLEN        64
`define RISCV_NUM_REGS    32
`define RISCV_REG_ADDR_W  5

// decoded control field widths
`define RISCV_ALU_OP_W    4
`define RISCV_BCOND_W     3

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=riscv_datapath_tb

verilator --binary --timing -j 0 \
  -f files.f \
  --top-module "$TOP" \
  -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench passed" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

// File: verification/riscv_datapath_tb.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_datapath_tb import riscv_pkg::*; ();

  logic    clk = 1'b0;
  logic    rst_n;
  ex_op_t  i_op;
  logic    i_op_valid;
  logic    o_op_ready;
  result_t o_res;
  logic    o_res_valid;
  logic    i_res_ready;

  // stimulus table, expected packets and entry names
  ex_op_t  ops [$];
  result_t exp_q [$];
  string   names [$];

  xlen_t       model_regs [`RISCV_NUM_REGS]; // sequential register file model
  xlen_t       next_pc;
  int          base_len;
  int          received;
  int          value_errors;
  int          other_errors;
  int          cycles;
  int          timeout_limit;
  logic [31:0] rng_state;
  logic        rand_ready; // back-pressure phase active

  always #2 clk = ~clk; // 4 ns period

  riscv_datapath dut_i (
    .i_riscv_datapath_clk (clk),
    .i_rst_n              (rst_n),
    .i_op                 (i_op),
    .i_op_valid           (i_op_valid),
    .o_op_ready           (o_op_ready),
    .o_res                (o_res),
    .o_res_valid          (o_res_valid),
    .i_res_ready          (i_res_ready)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference alu from the opcode definitions
  function automatic xlen_t alu_ref(alu_op_e f, xlen_t a, xlen_t b);
    case (f)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[5:0];
      ALU_SRL:  return a >> b[5:0];
      ALU_SRA:  return $signed(a) >>> b[5:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_ref(bcond_e c, xlen_t a, xlen_t b);
    case (c)
      BC_EQ:   return a == b;
      BC_NE:   return a != b;
      BC_LT:   return $signed(a) < $signed(b);
      BC_GE:   return $signed(a) >= $signed(b);
      BC_LTU:  return a < b;
      BC_GEU:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ex_op_t make_op(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                                     longint imm, alu_op_e f, bcond_e c,
                                     logic asel, logic bsel, logic regw, logic jump);
    ex_op_t op;
    op        = '0;
    op.rd     = rd;
    op.rs1    = rs1;
    op.rs2    = rs2;
    op.imm    = imm;
    op.alu_op = f;
    op.bcond  = c;
    op.asel   = asel;
    op.bsel   = bsel;
    op.regw   = regw;
    op.jump   = jump;
    return op;
  endfunction

  // runs the model on one op and appends it to the table
  task automatic push_entry(string name, ex_op_t op);
    xlen_t   rs1d;
    xlen_t   rs2d;
    xlen_t   alu;
    result_t r;
    op.pc   = next_pc;
    next_pc = next_pc + 64'd4;
    rs1d = (op.rs1 == 0) ? '0 : model_regs[op.rs1];
    rs2d = (op.rs2 == 0) ? '0 : model_regs[op.rs2];
    alu  = alu_ref(op.alu_op, op.asel ? op.pc : rs1d, op.bsel ? op.imm : rs2d);
    r.pc       = op.pc;
    r.rd       = op.rd;
    r.regw     = op.regw;
    r.rd_data  = op.jump ? op.pc + 64'd4 : alu; // link value for jumps
    r.redirect = op.jump || branch_ref(op.bcond, rs1d, rs2d);
    r.target   = alu;
    if (op.regw && op.rd != 0) begin
      model_regs[op.rd] = r.rd_data;
    end
    ops.push_back(op);
    exp_q.push_back(r);
    names.push_back(name);
  endtask

  task automatic imm_op(string name, reg_addr_t rd, reg_addr_t rs1, longint imm, alu_op_e f);
    push_entry(name, make_op(rd, rs1, 0, imm, f, BC_NONE, 1'b0, 1'b1, 1'b1, 1'b0));
  endtask

  task automatic reg_op(string name, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                        alu_op_e f);
    push_entry(name, make_op(rd, rs1, rs2, 0, f, BC_NONE, 1'b0, 1'b0, 1'b1, 1'b0));
  endtask

  // target is pc + imm through the alu
  task automatic branch_op(string name, reg_addr_t rs1, reg_addr_t rs2, bcond_e c);
    push_entry(name, make_op(0, rs1, rs2, 16, ALU_ADD, c, 1'b1, 1'b1, 1'b0, 1'b0));
  endtask

  task automatic jump_op(string name, reg_addr_t rd, reg_addr_t rs1, longint imm,
                         logic use_pc);
    push_entry(name, make_op(rd, rs1, 0, imm, ALU_ADD, BC_NONE, use_pc, 1'b1, 1'b1, 1'b1));
  endtask

  task automatic build_base();
    imm_op("addi x1", 1, 0, 5, ALU_ADD);
    imm_op("addi x2", 2, 0, -3, ALU_ADD);
    reg_op("add dep", 3, 1, 2, ALU_ADD);   // needs x2 right behind its write
    reg_op("sub dep", 4, 3, 1, ALU_SUB);
    reg_op("and", 5, 1, 2, ALU_AND);
    reg_op("or", 5, 1, 2, ALU_OR);
    reg_op("xor", 5, 5, 2, ALU_XOR);
    imm_op("slli", 6, 1, 35, ALU_SLL);     // shift amount above 31
    reg_op("srl", 7, 2, 1, ALU_SRL);
    imm_op("srai", 8, 2, 4, ALU_SRA);
    reg_op("slt", 9, 2, 1, ALU_SLT);
    reg_op("sltu", 10, 2, 1, ALU_SLTU);
    imm_op("write x0", 0, 1, 99, ALU_ADD);
    reg_op("read x0", 11, 0, 1, ALU_ADD);  // x0 must still be zero
    branch_op("beq taken", 1, 1, BC_EQ);
    branch_op("beq not", 1, 2, BC_EQ);
    branch_op("bne", 1, 2, BC_NE);
    branch_op("blt", 2, 1, BC_LT);
    branch_op("bge", 2, 1, BC_GE);
    branch_op("bltu", 2, 1, BC_LTU);
    branch_op("bgeu", 2, 1, BC_GEU);
    branch_op("no branch", 1, 1, BC_NONE);
    jump_op("jal", 12, 0, 64, 1'b1);
    jump_op("jalr", 13, 1, 40, 1'b0);
    reg_op("use link", 14, 12, 13, ALU_ADD);
  endtask

  task automatic check_xlen(string name, xlen_t exp, xlen_t act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg_addr(string name, reg_addr_t exp, reg_addr_t act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic drive_ops();
    logic taken;
    for (int i = 0; i < ops.size(); i++) begin
      i_op       = ops[i];
      i_op_valid = 1'b1;
      taken      = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = o_op_ready; // handshake settles mid-cycle
        @(posedge clk);
      end
      #1;
    end
    i_op_valid = 1'b0;
    i_op       = '0;
  endtask

  task automatic collect_results();
    string tag;
    while (received < exp_q.size()) begin
      @(negedge clk);
      if (o_res_valid && i_res_ready) begin
        tag = $sformatf("%s #%0d", names[received], received);
        check_xlen({tag, " pc"}, exp_q[received].pc, o_res.pc);
        check_reg_addr({tag, " rd"}, exp_q[received].rd, o_res.rd);
        check_xlen({tag, " rd_data"}, exp_q[received].rd_data, o_res.rd_data);
        check_flag({tag, " regw"}, exp_q[received].regw, o_res.regw);
        check_flag({tag, " redirect"}, exp_q[received].redirect, o_res.redirect);
        check_xlen({tag, " target"}, exp_q[received].target, o_res.target);
        received++;
        if (received >= base_len) begin
          rand_ready = 1'b1;
        end
      end
    end
  endtask

  // ready changes only 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (rand_ready) begin
      rng_state   = xorshift32(rng_state);
      i_res_ready = rng_state[4];
    end else begin
      i_res_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("timeout after %0d cycles with %0d of %0d results received",
               cycles, received, exp_q.size());
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    rst_n        = 1'b0;
    i_op         = '0;
    i_op_valid   = 1'b0;
    i_res_ready  = 1'b1;
    rand_ready   = 1'b0;
    rng_state    = 32'd17;
    received     = 0;
    value_errors = 0;
    other_errors = 0;
    cycles       = 0;
    next_pc      = 64'h8000_0000;
    for (int i = 0; i < `RISCV_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    build_base();
    base_len = ops.size();
    build_base(); // second pass runs under random back-pressure
    timeout_limit = ops.size() * 8 + 50;

    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_flag("reset o_res_valid", 1'b0, o_res_valid);
    check_flag("reset o_op_ready", 1'b1, o_op_ready);
    @(posedge clk);
    #1;

    fork
      drive_ops();
      collect_results();
    join

    repeat (8) begin
      @(negedge clk);
      if (o_res_valid) begin
        other_errors++;
        $display("a result arrived with no expected entry left in the table");
      end
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
